//--- compile.f
design/hdr_pkg.sv
design/ipv4_checksum_gen.sv
design/udp_pseudo_sum.sv
design/frame_hdr_assembler.sv
design/udp_ipv4_hdr_gen.sv
test/tb_udp_ipv4_hdr_gen.sv

//--- design/frame_hdr_assembler.sv
// Packs delayed request fields and both unit results into the 42-byte header
// No back-pressure, the consumer must take one header per cycle

`timescale 1ns/100ps

module frame_hdr_assembler (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  hdr_pkg::hdr_req_t   hdr_in,
    input  logic                ip_valid,
    input  hdr_pkg::len16_t     ip_length,
    input  hdr_pkg::csum_t      ip_csum,
    input  hdr_pkg::len16_t     udp_length,
    input  hdr_pkg::csum_t      udp_psum,
    output logic                hdr_valid,
    output hdr_pkg::frame_hdr_t hdr_out
);

    import hdr_pkg::*;

    hdr_req_t   hdr_d1;
    hdr_req_t   hdr_d2;                 // Lines up with the unit results
    logic       req_d1;
    logic       req_d2;
    frame_hdr_t hdr_c;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_d1    <= 1'b0;
            req_d2    <= 1'b0;
            hdr_valid <= 1'b0;
        end else begin
            req_d1    <= req;
            req_d2    <= req_d1;
            hdr_valid <= ip_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req)    hdr_d1 <= hdr_in;
        if (req_d1) hdr_d2 <= hdr_d1;
    end

    always_comb begin
        hdr_c.dst_mac        = hdr_d2.dst_mac;
        hdr_c.src_mac        = hdr_d2.src_mac;
        hdr_c.ethertype      = ETHERTYPE_IPV4;
        hdr_c.version        = IP_VERSION;
        hdr_c.ihl            = IP_IHL;
        hdr_c.dscp           = hdr_d2.dscp;
        hdr_c.ecn            = hdr_d2.ecn;
        hdr_c.ip_length      = ip_length;
        hdr_c.identification = hdr_d2.identification;
        hdr_c.flags          = hdr_d2.flags;
        hdr_c.frag_offset    = hdr_d2.frag_offset;
        hdr_c.ttl            = hdr_d2.ttl;
        hdr_c.protocol       = IP_PROTO_UDP;
        hdr_c.ip_csum        = ip_csum;
        hdr_c.src_ip         = hdr_d2.src_ip;
        hdr_c.dst_ip         = hdr_d2.dst_ip;
        hdr_c.src_port       = hdr_d2.src_port;
        hdr_c.dst_port       = hdr_d2.dst_port;
        hdr_c.udp_length     = udp_length;
        hdr_c.udp_csum       = udp_psum;    // Partial sum, finished by payload logic
    end

    always_ff @(posedge clk) begin
        if (ip_valid) hdr_out <= hdr_c;
    end

    // The field delay line and the checksum units must see the same requests
    a_unit_align: assert property (@(posedge clk) disable iff (!rst_n)
        req_d2 == ip_valid)
        else $error("checksum unit valid out of step with field pipeline");

endmodule

//--- design/hdr_pkg.sv
// Shared types and constants for the Ethernet/IPv4/UDP header generator
// IPv4 options and VLAN tags are not supported, so IHL is always 5

package hdr_pkg;

    typedef logic [47:0] mac_addr_t;    // Ethernet MAC address
    typedef logic [31:0] ip_addr_t;     // IPv4 address
    typedef logic [15:0] port_t;        // UDP port number
    typedef logic [15:0] len16_t;       // Byte length as carried in IP and UDP headers
    typedef logic [15:0] csum_t;        // Ones' complement checksum or partial sum

    // Per-packet request from the host
    typedef struct packed {
        mac_addr_t   dst_mac;
        mac_addr_t   src_mac;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] frag_offset;
        logic [7:0]  ttl;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        port_t       src_port;
        port_t       dst_port;
        len16_t      payload_len;       // UDP payload bytes only
    } hdr_req_t;

    // Assembled 42-byte header, first byte on the wire in the top bits
    typedef struct packed {
        mac_addr_t   dst_mac;
        mac_addr_t   src_mac;
        logic [15:0] ethertype;
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        len16_t      ip_length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] frag_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        csum_t       ip_csum;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        port_t       src_port;
        port_t       dst_port;
        len16_t      udp_length;
        csum_t       udp_csum;          // Uncomplemented partial sum, finished downstream
    } frame_hdr_t;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [3:0]  IP_VERSION     = 4'd4;
    localparam logic [3:0]  IP_IHL         = 4'd5;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam len16_t      IPV4_HDR_BYTES = 16'd20;
    localparam len16_t      UDP_HDR_BYTES  = 16'd8;

endpackage

//--- design/ipv4_checksum_gen.sv
// IPv4 total length and header checksum, results two edges after req
// Assumes a fixed 20-byte header carrying UDP, with no options

`timescale 1ns/100ps

module ipv4_checksum_gen #(
    parameter int unsigned MAX_PAYLOAD = 1472
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  hdr_pkg::hdr_req_t hdr_in,
    output logic              ip_valid,
    output hdr_pkg::len16_t   ip_length,
    output hdr_pkg::csum_t    ip_csum
);

    import hdr_pkg::*;

    len16_t      len_c;
    csum_t       words [9];
    logic [19:0] sum_c;                 // Nine 16-bit words fit in 20 bits
    logic [19:0] sum_s1;
    len16_t      len_s1;
    logic [16:0] fold1;
    logic [16:0] fold2;
    logic        req_d;

    assign len_c = hdr_in.payload_len + IPV4_HDR_BYTES + UDP_HDR_BYTES;

    // The checksum word itself is taken as zero and so left out
    always_comb begin
        words[0] = {IP_VERSION, IP_IHL, hdr_in.dscp, hdr_in.ecn};
        words[1] = len_c;
        words[2] = hdr_in.identification;
        words[3] = {hdr_in.flags, hdr_in.frag_offset};
        words[4] = {hdr_in.ttl, IP_PROTO_UDP};
        words[5] = hdr_in.src_ip[31:16];
        words[6] = hdr_in.src_ip[15:0];
        words[7] = hdr_in.dst_ip[31:16];
        words[8] = hdr_in.dst_ip[15:0];
        sum_c = '0;
        for (int i = 0; i < 9; i++) begin
            sum_c = sum_c + 20'(words[i]);
        end
    end

    // Two folds are enough since the first leaves at most one carry
    assign fold1 = 17'(sum_s1[15:0]) + 17'(sum_s1[19:16]);
    assign fold2 = 17'(fold1[15:0]) + 17'(fold1[16]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_d    <= 1'b0;
            ip_valid <= 1'b0;
        end else begin
            req_d    <= req;
            ip_valid <= req_d;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            sum_s1 <= sum_c;            // Stage 1
            len_s1 <= len_c;
        end
        if (req_d) begin
            ip_length <= len_s1;        // Stage 2
            ip_csum   <= ~fold2[15:0];
        end
    end

    a_payload_len: assert property (@(posedge clk) disable iff (!rst_n)
        req |-> (32'(hdr_in.payload_len) <= MAX_PAYLOAD))
        else $error("payload_len %0d above MAX_PAYLOAD", hdr_in.payload_len);

endmodule

//--- design/udp_ipv4_hdr_gen.sv
// UDP/IPv4/Ethernet header generator, hdr_valid follows req by three cycles
// Accepts one request per cycle, payload_len must not exceed MAX_PAYLOAD

`timescale 1ns/100ps

module udp_ipv4_hdr_gen #(
    parameter int unsigned MAX_PAYLOAD = 1472
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  hdr_pkg::hdr_req_t   hdr_in,
    output logic                hdr_valid,
    output hdr_pkg::frame_hdr_t hdr_out
);

    import hdr_pkg::*;

    logic   ip_valid;
    len16_t ip_length;
    csum_t  ip_csum;
    len16_t udp_length;
    csum_t  udp_psum;

    ipv4_checksum_gen #(
        .MAX_PAYLOAD (MAX_PAYLOAD)
    ) u_ipv4_csum (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .hdr_in    (hdr_in),
        .ip_valid  (ip_valid),
        .ip_length (ip_length),
        .ip_csum   (ip_csum)
    );

    udp_pseudo_sum u_udp_psum (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .hdr_in     (hdr_in),
        .udp_length (udp_length),
        .udp_psum   (udp_psum)
    );

    frame_hdr_assembler u_assembler (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .hdr_in     (hdr_in),
        .ip_valid   (ip_valid),
        .ip_length  (ip_length),
        .ip_csum    (ip_csum),
        .udp_length (udp_length),
        .udp_psum   (udp_psum),
        .hdr_valid  (hdr_valid),
        .hdr_out    (hdr_out)
    );

endmodule

//--- design/udp_pseudo_sum.sv
// UDP length and folded pseudo-header sum, results two edges after req
// The sum is left uncomplemented so payload words can be added downstream

`timescale 1ns/100ps

module udp_pseudo_sum (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  hdr_pkg::hdr_req_t hdr_in,
    output hdr_pkg::len16_t   udp_length,
    output hdr_pkg::csum_t    udp_psum
);

    import hdr_pkg::*;

    len16_t      len_c;
    csum_t       words [9];
    logic [19:0] sum_c;
    logic [19:0] sum_s1;
    len16_t      len_s1;
    logic [16:0] fold1;
    logic [16:0] fold2;
    logic        req_d;                 // Stage 2 load enable

    assign len_c = hdr_in.payload_len + UDP_HDR_BYTES;

    always_comb begin
        words[0] = hdr_in.src_ip[31:16];
        words[1] = hdr_in.src_ip[15:0];
        words[2] = hdr_in.dst_ip[31:16];
        words[3] = hdr_in.dst_ip[15:0];
        words[4] = {8'h00, IP_PROTO_UDP};
        words[5] = len_c;               // Length from the pseudo-header
        words[6] = len_c;               // Length from the UDP header itself
        words[7] = hdr_in.src_port;
        words[8] = hdr_in.dst_port;
        sum_c = '0;
        for (int i = 0; i < 9; i++) begin
            sum_c = sum_c + 20'(words[i]);
        end
    end

    assign fold1 = 17'(sum_s1[15:0]) + 17'(sum_s1[19:16]);
    assign fold2 = 17'(fold1[15:0]) + 17'(fold1[16]);

    always_ff @(posedge clk) begin
        if (!rst_n) req_d <= 1'b0;
        else        req_d <= req;
    end

    // Same stage timing as the IPv4 unit, so ip_valid also marks these results
    always_ff @(posedge clk) begin
        if (req) begin
            sum_s1 <= sum_c;
            len_s1 <= len_c;
        end
        if (req_d) begin
            udp_length <= len_s1;
            udp_psum   <= fold2[15:0];
        end
    end

endmodule

//--- test/tb_udp_ipv4_hdr_gen.sv
// Directed tests of the UDP/IPv4 header generator with outputs sampled on the falling edge
// Payload lengths stay within MAX_PAYLOAD so the payload assertion never fires

`timescale 1ns/100ps

module tb_udp_ipv4_hdr_gen;

    import hdr_pkg::*;

    localparam int unsigned MAX_PAYLOAD    = 1472;
    localparam int          TIMEOUT_CYCLES = 50;

    logic       clk;
    logic       rst_n;
    logic       req;
    hdr_req_t   hdr_in;
    logic       hdr_valid;
    frame_hdr_t hdr_out;

    frame_hdr_t exp_q[$];              // Expected headers in request order
    int         rx_count;
    int         run_len;
    int         max_run;                // Longest run of back-to-back headers

    udp_ipv4_hdr_gen #(
        .MAX_PAYLOAD (MAX_PAYLOAD)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .hdr_in    (hdr_in),
        .hdr_valid (hdr_valid),
        .hdr_out   (hdr_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [335:0] got,
                               input logic [335:0] want);
        if (got !== want) begin
            $display("FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, want);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // Ones' complement add with the end-around carry applied at once
    function automatic csum_t oc_add(input csum_t a, input csum_t b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[15:0] + 16'(s[16]);
    endfunction

    function automatic frame_hdr_t expected_hdr(input hdr_req_t r);
        frame_hdr_t h;
        csum_t      s;
        h.dst_mac        = r.dst_mac;
        h.src_mac        = r.src_mac;
        h.ethertype      = 16'h0800;
        h.version        = 4'd4;
        h.ihl            = 4'd5;
        h.dscp           = r.dscp;
        h.ecn            = r.ecn;
        h.ip_length      = r.payload_len + 16'd28;  // IPv4 and UDP headers on top of payload
        h.identification = r.identification;
        h.flags          = r.flags;
        h.frag_offset    = r.frag_offset;
        h.ttl            = r.ttl;
        h.protocol       = 8'd17;
        h.src_ip         = r.src_ip;
        h.dst_ip         = r.dst_ip;
        h.src_port       = r.src_port;
        h.dst_port       = r.dst_port;
        h.udp_length     = r.payload_len + 16'd8;
        s = 16'h0000;
        s = oc_add(s, {4'd4, 4'd5, r.dscp, r.ecn});
        s = oc_add(s, h.ip_length);
        s = oc_add(s, r.identification);
        s = oc_add(s, {r.flags, r.frag_offset});
        s = oc_add(s, {r.ttl, 8'd17});
        s = oc_add(s, r.src_ip[31:16]);
        s = oc_add(s, r.src_ip[15:0]);
        s = oc_add(s, r.dst_ip[31:16]);
        s = oc_add(s, r.dst_ip[15:0]);
        h.ip_csum = ~s;
        s = 16'h0000;
        s = oc_add(s, r.src_ip[31:16]);
        s = oc_add(s, r.src_ip[15:0]);
        s = oc_add(s, r.dst_ip[31:16]);
        s = oc_add(s, r.dst_ip[15:0]);
        s = oc_add(s, 16'd17);
        s = oc_add(s, h.udp_length);            // Pseudo-header length
        s = oc_add(s, h.udp_length);            // UDP header length
        s = oc_add(s, r.src_port);
        s = oc_add(s, r.dst_port);
        h.udp_csum = s;                         // Left uncomplemented
        return h;
    endfunction

    function automatic hdr_req_t random_req();
        hdr_req_t r;
        r.dst_mac        = {16'($urandom), $urandom};
        r.src_mac        = {16'($urandom), $urandom};
        r.dscp           = 6'($urandom);
        r.ecn            = 2'($urandom);
        r.identification = 16'($urandom);
        r.flags          = 3'($urandom);
        r.frag_offset    = 13'($urandom);
        r.ttl            = 8'($urandom);
        r.src_ip         = $urandom;
        r.dst_ip         = $urandom;
        r.src_port       = 16'($urandom);
        r.dst_port       = 16'($urandom);
        r.payload_len    = 16'($urandom_range(MAX_PAYLOAD, 0));
        return r;
    endfunction

    task automatic send_req(input hdr_req_t r);
        @(posedge clk);
        req    <= 1'b1;
        hdr_in <= r;
        exp_q.push_back(expected_hdr(r));
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        req <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        idle_cycle();
        while (exp_q.size() != 0 && n < TIMEOUT_CYCLES) begin
            idle_cycle();
            n++;
        end
        if (exp_q.size() != 0) fail_now("expected headers still pending after timeout");
    endtask

    // Counts rising edges from the request edge until hdr_valid is seen
    task automatic measure_latency(output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            idle_cycle();
            cycles++;
            @(negedge clk);
            seen = hdr_valid;
        end
        if (!seen) fail_now("hdr_valid never rose after a request");
    endtask

    always @(negedge clk) begin
        frame_hdr_t want;
        if (rst_n && hdr_valid) begin
            if (exp_q.size() == 0) begin
                fail_now("hdr_valid with no outstanding request");
            end else begin
                want = exp_q.pop_front();
                check_value("hdr_out.ip_length", hdr_out.ip_length, want.ip_length);
                check_value("hdr_out.ip_csum", hdr_out.ip_csum, want.ip_csum);
                check_value("hdr_out.udp_length", hdr_out.udp_length, want.udp_length);
                check_value("hdr_out.udp_csum", hdr_out.udp_csum, want.udp_csum);
                check_value("hdr_out", hdr_out, want);
                rx_count++;
                run_len++;
                if (run_len > max_run) max_run = run_len;
            end
        end else begin
            run_len = 0;
        end
    end

    task automatic reset_idle();
        repeat (6) begin
            @(negedge clk);
            check_value("hdr_valid", hdr_valid, 1'b0);
        end
    endtask

    task automatic known_headers();
        hdr_req_t   r;
        frame_hdr_t want;
        int         cycles;
        r = '0;
        r.dst_mac     = 48'h0200_0000_0001;
        r.src_mac     = 48'h0200_0000_0002;
        r.flags       = 3'b010;               // Don't fragment
        r.ttl         = 8'h40;
        r.src_ip      = 32'hc0a8_0001;
        r.dst_ip      = 32'hc0a8_00c7;
        r.src_port    = 16'h1388;
        r.dst_port    = 16'h0035;
        r.payload_len = 16'd87;               // Total length 0x0073
        want = expected_hdr(r);
        check_value("model ip_csum", want.ip_csum, 16'hb861);
        check_value("model udp_csum", want.udp_csum, 16'h96a5);
        send_req(r);
        measure_latency(cycles);
        check_value("hdr_valid latency", cycles, 3);
        wait_drain();
        r.payload_len = 16'd0;
        want = expected_hdr(r);
        check_value("model ip_length", want.ip_length, 16'd28);
        check_value("model udp_length", want.udp_length, 16'd8);
        send_req(r);
        measure_latency(cycles);
        check_value("hdr_valid latency", cycles, 3);
        wait_drain();
    endtask

    task automatic carry_folding();
        hdr_req_t   r;
        frame_hdr_t want;
        r = '1;
        r.payload_len    = 16'(MAX_PAYLOAD);
        r.identification = 16'hb518;          // Brings the IPv4 sum to 0x6ffff so the first fold carries out again
        r.dst_port       = 16'hf463;          // Brings the UDP sum to 0x5ffff for a second carry too
        want = expected_hdr(r);
        check_value("model ip_csum", want.ip_csum, 16'hfff9);
        check_value("model udp_csum", want.udp_csum, 16'h0005);
        send_req(r);
        r.ttl = 8'h00;                        // Second request with one field changed
        send_req(r);
        wait_drain();
    endtask

    task automatic burst_traffic();
        int start;
        start   = rx_count;
        max_run = 0;
        repeat (16) send_req(random_req());
        wait_drain();
        check_value("burst header count", rx_count - start, 16);
        check_value("burst consecutive run", max_run, 16);
    endtask

    task automatic gapped_traffic();
        int start;
        start = rx_count;
        repeat (40) begin
            send_req(random_req());
            repeat ($urandom_range(3, 0)) idle_cycle();
        end
        wait_drain();
        check_value("gapped header count", rx_count - start, 40);
    endtask

    initial begin
        void'($urandom(32'ha94bba8c));
        rx_count = 0;
        run_len  = 0;
        max_run  = 0;
        rst_n    = 1'b0;
        req      = 1'b0;
        hdr_in   = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        reset_idle();
        known_headers();
        carry_folding();
        burst_traffic();
        gapped_traffic();
        repeat (4) idle_cycle();
        if (exp_q.size() != 0) begin
            fail_now("expected header queue not empty at end of run");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule
